/* Bender.yml */
package:
  name: branch_predictor

sources:
  - common/bp_pkg.sv
  - verilog/pred_table.sv
  - pht/pht.sv
  - btb/btb.sv
  - verilog/bp_resolve.sv
  - verilog/branch_predictor.sv
  - target: test
    files:
      - bench/tb_branch_predictor.sv

/* bench/tb_branch_predictor.sv */
`timescale 1ns/10ps

module tb_branch_predictor import bp_pkg::*; ();

    typedef struct packed {
        logic       fill;        // non-branch filler row with random pcs
        opcode_t    opcode_id;
        word_t      pc_id;
        opcode_t    opcode_mem;
        word_t      pc_mem;
        word_t      target_mem;
        logic       br_en_mem;
        pcmux_sel_t exp_sel;
        logic       exp_flush;
        logic       exp_flush_id;
        word_t      exp_target;  // compared only when btb_out is expected
    } row_t;

    localparam word_t pc_a  = 32'h0000_0100; // btb index 0 and tag 4
    localparam word_t pc_b  = 32'h0000_0148; // index 2
    localparam word_t pc_c  = 32'h0000_0210; // index 4 and the taken target of pc_a
    localparam word_t pc_j  = 32'h0000_0318; // jalr at index 6
    localparam word_t pc_l  = 32'h0000_0224; // jal at index 9
    localparam word_t pc_x  = 32'h0000_1100; // same index as pc_a but another tag
    localparam word_t tgt_b = 32'h0000_0180;
    localparam word_t tgt_c = 32'h0000_0280;
    localparam word_t tgt_j = 32'h0000_0404;
    localparam word_t tgt_l = 32'h0000_0500;

    logic       clk;
    logic       arst_n;
    opcode_t    opcode_id;
    word_t      pc_id;
    opcode_t    opcode_mem;
    word_t      pc_mem;
    word_t      target_mem;
    logic       br_en_mem;
    pcmux_sel_t pcmux_sel;
    logic       flush;
    logic       flush_id;
    word_t      pred_target;

    row_t rows[$];
    int   seed   = 32'h6b61;
    int   errors = 0;
    int   waited;

    branch_predictor branch_predictor_inst (
        .clk         (clk),
        .arst_n      (arst_n),
        .opcode_id   (opcode_id),
        .pc_id       (pc_id),
        .opcode_mem  (opcode_mem),
        .pc_mem      (pc_mem),
        .target_mem  (target_mem),
        .br_en_mem   (br_en_mem),
        .pcmux_sel   (pcmux_sel),
        .flush       (flush),
        .flush_id    (flush_id),
        .pred_target (pred_target)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    task automatic add_row(input logic fill, input opcode_t op_i, input word_t pc_i,
                           input opcode_t op_m, input word_t pc_m, input word_t tgt_m,
                           input logic br_en, input pcmux_sel_t sel, input logic fl,
                           input logic fl_id, input word_t tgt);
        row_t r;
        r = '{fill, op_i, pc_i, op_m, pc_m, tgt_m, br_en, sel, fl, fl_id, tgt};
        rows.push_back(r);
    endtask

    task automatic drive_row(input row_t r);
        word_t rnd;
        rnd = $random(seed);
        if (r.fill) begin
            opcode_id  <= rnd[1] ? op_imm : op_reg;
            opcode_mem <= rnd[2] ? op_imm : op_reg;
            br_en_mem  <= rnd[0]; // no effect without a branch in MEM
            pc_id      <= $random(seed);
            pc_mem     <= $random(seed);
            target_mem <= $random(seed);
        end else begin
            opcode_id  <= r.opcode_id;
            pc_id      <= r.pc_id;
            opcode_mem <= r.opcode_mem;
            pc_mem     <= r.pc_mem;
            target_mem <= r.target_mem;
            br_en_mem  <= r.br_en_mem;
        end
    endtask

    task automatic verify_outputs(input int idx, input row_t r);
        if (pcmux_sel !== r.exp_sel) begin
            $display("[ERROR] %0t row %0d pcmux_sel expected %0d got %0d",
                     $time, idx, r.exp_sel, pcmux_sel);
            errors++;
        end
        if (flush !== r.exp_flush) begin
            $display("[ERROR] %0t row %0d flush expected %b got %b",
                     $time, idx, r.exp_flush, flush);
            errors++;
        end
        if (flush_id !== r.exp_flush_id) begin
            $display("[ERROR] %0t row %0d flush_id expected %b got %b",
                     $time, idx, r.exp_flush_id, flush_id);
            errors++;
        end
        if (r.exp_sel == btb_out && pred_target !== r.exp_target) begin
            $display("[ERROR] %0t row %0d pred_target expected %h got %h",
                     $time, idx, r.exp_target, pred_target);
            errors++;
        end
    endtask

    initial begin
        arst_n     = 1'b0;
        opcode_id  = op_imm;
        pc_id      = '0;
        opcode_mem = op_imm;
        pc_mem     = '0;
        target_mem = '0;
        br_en_mem  = 1'b0;

        // fill, ID op/pc, MEM op/pc/target, br_en, expected sel, flush, flush_id, target
        add_row(1, op_imm,  0,    op_imm,  0,    0,     0, pc_plus4,     0, 0, 0);
        add_row(1, op_imm,  0,    op_imm,  0,    0,     0, pc_plus4,     0, 0, 0);
        add_row(0, op_br,   pc_a, op_imm,  0,    0,     0, pc_plus4,     0, 0, 0); // btb empty
        add_row(1, op_imm,  0,    op_imm,  0,    0,     0, pc_plus4,     0, 0, 0);
        add_row(0, op_imm,  0,    op_br,   pc_b, tgt_b, 0, pc_plus4,     0, 0, 0);
        add_row(0, op_imm,  0,    op_br,   pc_a, pc_c,  1, alu_out,      1, 0, 0);
        add_row(0, op_imm,  0,    op_jalr, pc_j, tgt_j, 0, alu_mod2,     1, 0, 0);
        add_row(0, op_imm,  0,    op_jal,  pc_l, tgt_l, 0, alu_out,      1, 0, 0);
        add_row(0, op_jal,  pc_l, op_imm,  0,    0,     0, btb_out,      0, 1, tgt_l);
        // btb hit with a not-taken counter also clears the flag
        add_row(0, op_br,   pc_a, op_imm,  0,    0,     0, pc_plus4,     0, 0, 0);
        // taken outcomes fill the history with ones and train that counter
        add_row(0, op_imm,  0,    op_br,   pc_a, pc_c,  1, alu_out,      1, 0, 0);
        add_row(0, op_imm,  0,    op_br,   pc_c, tgt_c, 1, alu_out,      1, 0, 0);
        add_row(0, op_imm,  0,    op_br,   pc_a, pc_c,  1, alu_out,      1, 0, 0);
        add_row(0, op_imm,  0,    op_br,   pc_a, pc_c,  1, alu_out,      1, 0, 0);
        add_row(0, op_imm,  0,    op_br,   pc_a, pc_c,  1, alu_out,      1, 0, 0);
        add_row(0, op_br,   pc_a, op_imm,  0,    0,     0, btb_out,      0, 1, pc_c);
        add_row(0, op_br,   pc_c, op_br,   pc_a, pc_c,  1, btb_out,      0, 1, tgt_c);
        add_row(0, op_imm,  0,    op_br,   pc_c, tgt_c, 0, pc_mem_plus4, 1, 0, 0);
        add_row(0, op_imm,  0,    op_br,   pc_a, pc_c,  1, pc_mem_plus4, 1, 0, 0); // unconfirmed
        add_row(0, op_br,   pc_x, op_imm,  0,    0,     0, pc_plus4,     0, 0, 0); // tag differs
        add_row(0, op_jalr, pc_j, op_imm,  0,    0,     0, btb_out,      0, 1, tgt_j);
        add_row(1, op_imm,  0,    op_imm,  0,    0,     0, pc_plus4,     0, 0, 0);
        add_row(1, op_imm,  0,    op_imm,  0,    0,     0, pc_plus4,     0, 0, 0);
        add_row(1, op_imm,  0,    op_imm,  0,    0,     0, pc_plus4,     0, 0, 0);

        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        waited = 0;
        while (arst_n !== 1'b1 && waited < 4) begin
            @(negedge clk);
            waited++;
        end

        if (arst_n !== 1'b1) begin
            $display("timeout while waiting for reset release");
            $display("Testbench failed");
            $finish;
        end else begin
            foreach (rows[i]) begin
                @(posedge clk);
                drive_row(rows[i]);
                @(negedge clk); // outputs settle well before the next edge
                verify_outputs(i, rows[i]);
            end
            $display("rows run: %0d, errors: %0d", rows.size(), errors);
            if (errors == 0) begin
                $display("Testbench passed");
            end else begin
                $display("Testbench failed");
            end
            $finish;
        end
    end

endmodule

/* btb/btb.sv */
`timescale 1ns/10ps

module btb import bp_pkg::*; (
    input  logic  clk,
    input  logic  arst_n,
    // lookup for the instruction in ID
    input  word_t pc_id,
    output logic  btb_hit,
    output word_t btb_target,
    // fill from the instruction resolving in MEM
    input  logic  write_btb,
    input  word_t pc_mem,
    input  word_t target_mem
);

    btb_idx_t   idx_id;
    btb_tag_t   tag_id;
    btb_idx_t   idx_mem;
    btb_tag_t   tag_mem;
    btb_entry_t rd_entry;
    btb_entry_t wr_entry;

    // pc = {tag, index, 2'b00}
    assign idx_id  = pc_id[btb_idx_bits+1:2];
    assign tag_id  = pc_id[xlen-1:btb_idx_bits+2];
    assign idx_mem = pc_mem[btb_idx_bits+1:2];
    assign tag_mem = pc_mem[xlen-1:btb_idx_bits+2];

    always_comb begin
        wr_entry.valid  = 1'b1;
        wr_entry.tag    = tag_mem;
        wr_entry.target = target_mem;
    end

    assign btb_hit    = rd_entry.valid && (rd_entry.tag == tag_id);
    assign btb_target = rd_entry.target; // only meaningful with btb_hit

    pred_table #(.entry_t(btb_entry_t), .depth(btb_depth), .reset_val(btb_empty)) entry_tbl (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr  (idx_id),
        .rdata  (rd_entry),
        .we     (write_btb),
        .waddr  (idx_mem),
        .wdata  (wr_entry)
    );

endmodule

/* common/bp_pkg.sv */
package bp_pkg;

    // machine word
    localparam int unsigned xlen = 32;

    typedef logic [xlen-1:0] word_t;

    // RV32I major opcodes seen by the predictor
    typedef enum logic [6:0] {
        op_br   = 7'b1100011, // conditional branch
        op_jal  = 7'b1101111,
        op_jalr = 7'b1100111,
        op_imm  = 7'b0010011, // non-branch, used as filler
        op_reg  = 7'b0110011
    } opcode_t;

    // fetch mux select
    typedef enum logic [2:0] {
        pc_plus4     = 3'd0,
        alu_out      = 3'd1, // branch or jal target
        alu_mod2     = 3'd2, // jalr target, bit 0 cleared
        btb_out      = 3'd3, // predicted target
        pc_mem_plus4 = 3'd4  // recovery after a wrong taken guess
    } pcmux_sel_t;

    // global history and pattern table
    localparam int unsigned hist_len  = 4;
    localparam int unsigned pht_depth = 1 << hist_len;

    typedef logic [hist_len-1:0] hist_t;

    // two-bit saturating counter
    // 0 and 1 predict not taken, 2 and 3 predict taken
    typedef logic [1:0] ctr_t;

    localparam ctr_t ctr_min   = 2'b00;
    localparam ctr_t ctr_max   = 2'b11;
    localparam ctr_t ctr_reset = 2'b01; // weakly not taken

    // target buffer geometry, pc[1:0] is never part of index or tag
    localparam int unsigned btb_idx_bits = 4;
    localparam int unsigned btb_depth    = 1 << btb_idx_bits;
    localparam int unsigned btb_tag_bits = xlen - btb_idx_bits - 2;

    typedef logic [btb_idx_bits-1:0] btb_idx_t;
    typedef logic [btb_tag_bits-1:0] btb_tag_t;

    typedef struct packed {
        logic     valid;
        btb_tag_t tag;
        word_t    target;
    } btb_entry_t;

    localparam btb_entry_t btb_empty = '0; // invalid entry

endpackage

/* pht/pht.sv */
`timescale 1ns/10ps

module pht import bp_pkg::*; (
    input  logic clk,
    input  logic arst_n,
    input  logic train_pht,      // MEM holds a control transfer
    input  logic mem_taken,      // its actual outcome
    output logic pred_taken_ctr  // msb of the counter for the current history
);

    hist_t hist_q;    // global history, newest outcome in bit 0
    hist_t hist_ex;   // history seen by the instruction now in EX
    hist_t hist_mem;  // history seen by the instruction now in MEM
    ctr_t  ctr_pred;
    ctr_t  ctr_train;
    ctr_t  ctr_next;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hist_q <= '0;
        end else if (train_pht) begin
            hist_q <= {hist_q[hist_len-2:0], mem_taken};
        end
    end

    // the index used at prediction time follows the instruction down to MEM,
    // so training hits the same counter that made the guess
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            hist_ex  <= '0;
            hist_mem <= '0;
        end else begin
            hist_ex  <= hist_q;
            hist_mem <= hist_ex;
        end
    end

    always_comb begin
        ctr_next = ctr_train;
        if (mem_taken && ctr_train != ctr_max) begin
            ctr_next = ctr_train + 2'd1;
        end else if (!mem_taken && ctr_train != ctr_min) begin
            ctr_next = ctr_train - 2'd1;
        end
    end

    assign pred_taken_ctr = ctr_pred[1];

    // two copies with identical writes give one read port per side
    pred_table #(.entry_t(ctr_t), .depth(pht_depth), .reset_val(ctr_reset)) pred_tbl (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr  (hist_q),
        .rdata  (ctr_pred),
        .we     (train_pht),
        .waddr  (hist_mem),
        .wdata  (ctr_next)
    );

    pred_table #(.entry_t(ctr_t), .depth(pht_depth), .reset_val(ctr_reset)) train_tbl (
        .clk    (clk),
        .arst_n (arst_n),
        .raddr  (hist_mem),
        .rdata  (ctr_train),
        .we     (train_pht),
        .waddr  (hist_mem),
        .wdata  (ctr_next)
    );

endmodule

/* verilog.f */
common/bp_pkg.sv
verilog/pred_table.sv
pht/pht.sv
btb/btb.sv
verilog/bp_resolve.sv
verilog/branch_predictor.sv
bench/tb_branch_predictor.sv

/* verilog/bp_resolve.sv */
`timescale 1ns/10ps

module bp_resolve import bp_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    // ID stage
    input  opcode_t    opcode_id,
    input  word_t      pc_id,
    // MEM stage
    input  opcode_t    opcode_mem,
    input  logic       br_en_mem,
    input  word_t      target_mem,
    // from the tables
    input  logic       pred_taken_ctr,
    input  logic       btb_hit,
    // training
    output logic       mem_taken,
    output logic       train_pht,
    output logic       write_btb,
    // fetch control
    output pcmux_sel_t pcmux_sel,
    output logic       flush,
    output logic       flush_id
);

    logic       is_ctl_id;
    logic       is_ctl_mem;
    logic       id_pred_taken;
    logic       pred_taken_q;  // guess made for the last control transfer in ID
    logic       confirm;
    pcmux_sel_t sel_dflt;
    logic       flush_dflt;

    assign is_ctl_id  = (opcode_id == op_br) || (opcode_id == op_jal) || (opcode_id == op_jalr);
    assign is_ctl_mem = (opcode_mem == op_br) || (opcode_mem == op_jal)
                     || (opcode_mem == op_jalr);

    assign mem_taken = (opcode_mem == op_jal) || (opcode_mem == op_jalr)
                    || ((opcode_mem == op_br) && br_en_mem);

    // jumps always predict taken, branches ask the counter; both need a btb hit
    assign id_pred_taken = ((opcode_id == op_jal) || (opcode_id == op_jalr)
                         || ((opcode_id == op_br) && pred_taken_ctr)) && btb_hit;

    assign confirm   = (pc_id == target_mem); // fetch already went the right way
    assign train_pht = is_ctl_mem;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            pred_taken_q <= 1'b0;
        end else if (is_ctl_id) begin
            pred_taken_q <= id_pred_taken;
        end
    end

    // select without any prediction
    always_comb begin
        if (((opcode_mem == op_br) && br_en_mem) || (opcode_mem == op_jal)) begin
            sel_dflt   = alu_out;
            flush_dflt = 1'b1;
        end else if (opcode_mem == op_jalr) begin
            sel_dflt   = alu_mod2;
            flush_dflt = 1'b1;
        end else begin
            sel_dflt   = pc_plus4;
            flush_dflt = 1'b0;
        end
    end

    always_comb begin
        pcmux_sel = sel_dflt;
        flush     = flush_dflt;
        flush_id  = 1'b0;
        write_btb = 1'b0;

        if (is_ctl_mem && pred_taken_q && mem_taken && confirm) begin
            // guess was right, nothing to undo
            write_btb = 1'b1;
            flush     = 1'b0;
            if (id_pred_taken) begin
                pcmux_sel = btb_out;
                flush_id  = 1'b1;
            end else begin
                pcmux_sel = pc_plus4;
            end
        end else if (is_ctl_mem && pred_taken_q) begin
            // wrong path fetched, restart after the MEM instruction
            pcmux_sel = pc_mem_plus4;
            flush     = 1'b1;
            write_btb = mem_taken;
        end else if (is_ctl_mem && mem_taken) begin
            write_btb = 1'b1; // missed taken transfer, default redirect
        end else if (id_pred_taken) begin
            // MEM not taken as guessed, or no control transfer in MEM
            pcmux_sel = btb_out;
            flush     = 1'b0;
            flush_id  = 1'b1;
        end
    end

endmodule

/* verilog/branch_predictor.sv */
`timescale 1ns/10ps

module branch_predictor import bp_pkg::*; (
    input  logic       clk,
    input  logic       arst_n,
    // ID stage
    input  opcode_t    opcode_id,
    input  word_t      pc_id,
    // MEM stage
    input  opcode_t    opcode_mem,
    input  word_t      pc_mem,
    input  word_t      target_mem,
    input  logic       br_en_mem,
    // fetch control
    output pcmux_sel_t pcmux_sel,
    output logic       flush,
    output logic       flush_id,
    output word_t      pred_target // feeds the btb_out leg of the fetch mux
);

    logic pred_taken_ctr;
    logic btb_hit;
    logic mem_taken;
    logic train_pht;
    logic write_btb;

    pht pht_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .train_pht      (train_pht),
        .mem_taken      (mem_taken),
        .pred_taken_ctr (pred_taken_ctr)
    );

    btb btb_inst (
        .clk        (clk),
        .arst_n     (arst_n),
        .pc_id      (pc_id),
        .btb_hit    (btb_hit),
        .btb_target (pred_target),
        .write_btb  (write_btb),
        .pc_mem     (pc_mem),
        .target_mem (target_mem)
    );

    bp_resolve bp_resolve_inst (
        .clk            (clk),
        .arst_n         (arst_n),
        .opcode_id      (opcode_id),
        .pc_id          (pc_id),
        .opcode_mem     (opcode_mem),
        .br_en_mem      (br_en_mem),
        .target_mem     (target_mem),
        .pred_taken_ctr (pred_taken_ctr),
        .btb_hit        (btb_hit),
        .mem_taken      (mem_taken),
        .train_pht      (train_pht),
        .write_btb      (write_btb),
        .pcmux_sel      (pcmux_sel),
        .flush          (flush),
        .flush_id       (flush_id)
    );

endmodule

/* verilog/pred_table.sv */
`timescale 1ns/10ps

module pred_table #(
    parameter type         entry_t   = logic [1:0],
    parameter int unsigned depth     = 16,
    parameter entry_t      reset_val = '0
) (
    input  logic                     clk,
    input  logic                     arst_n,
    // asynchronous read
    input  logic [$clog2(depth)-1:0] raddr,
    output entry_t                   rdata,
    // synchronous write
    input  logic                     we,
    input  logic [$clog2(depth)-1:0] waddr,
    input  entry_t                   wdata
);

    entry_t mem [depth];

    assign rdata = mem[raddr];

    // every entry goes back to reset_val so no stale prediction survives reset
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < depth; i++) begin
                mem[i] <= reset_val;
            end
        end else if (we) begin
            mem[waddr] <= wdata;
        end
    end

endmodule
